/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rename_core_tb \
		-f vlog.f -Mdir obj_dir -o rename_core_tb
	./obj_dir/rename_core_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* source/circular_fifo.sv */
`timescale 1ns/1ps

module circular_fifo #(
    parameter type T          = logic,
    parameter int  DEPTH      = 4,
    parameter bit  RESET_FILL = 1'b0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= RESET_FILL ? CW'(DEPTH) : '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    if (RESET_FILL) begin : g_fill
        // Free list starts holding every register above the architectural range
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= T'(rename_pkg::ARCH_REGS + i);
                end
            end else if (do_push && !flush) begin
                mem[wr_ptr] <= push_data;
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk) begin
            if (do_push && !flush) begin
                mem[wr_ptr] <= push_data;
            end
        end
    end

endmodule

/* source/recovery_fsm.sv */
`timescale 1ns/1ps

module recovery_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                commit_valid,
    input  rename_pkg::commit_t commit,
    input  logic                rob_empty,
    output logic                squash_step,
    output logic                restore,
    output logic                accepting
);

    typedef enum logic {
        RUN,
        SQUASH
    } state_t;

    state_t state;
    state_t state_next;

    // Mispredicted branch reaching commit starts recovery
    assign restore     = (state == RUN) && commit_valid && commit.mispredict;
    assign squash_step = (state == SQUASH) && !rob_empty;
    // Also closed on the restore edge so a new request is not flushed
    assign accepting   = (state == RUN) && !restore;

    always_comb begin
        state_next = state;
        case (state)
            RUN:     if (restore) state_next = SQUASH;
            SQUASH:  if (rob_empty) state_next = RUN;
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* source/rename_core.sv */
`timescale 1ns/1ps

module rename_core #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  rename_pkg::rename_req_t  in_req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rename_pkg::renamed_uop_t out_uop,
    input  logic                     cpl_valid,
    input  rename_pkg::completion_t  cpl,
    output logic                     commit_valid,
    output rename_pkg::commit_t      commit
);

    logic                    iq_full;
    logic                    iq_empty;
    logic                    iq_pop;
    rename_pkg::rename_req_t iq_data;
    rename_pkg::preg_t       free_head;
    logic                    free_pop;
    logic                    release_valid;
    rename_pkg::preg_t       release_preg;
    rename_pkg::areg_t       rs1;
    rename_pkg::areg_t       rs2;
    rename_pkg::areg_t       rd;
    rename_pkg::preg_t       prs1;
    rename_pkg::preg_t       prs2;
    rename_pkg::preg_t       old_prd;
    logic                    rename_we;
    rename_pkg::preg_t       new_prd;
    logic                    alloc;
    rename_pkg::rob_alloc_t  alloc_entry;
    rename_pkg::rob_id_t     rob_head;
    rename_pkg::rob_id_t     rob_tail;
    logic                    rob_full;
    logic                    rob_empty;
    logic                    squash_step;
    logic                    restore;
    logic                    accepting;

    assign in_ready = !iq_full && accepting;

    circular_fifo #(.T(rename_pkg::rename_req_t), .DEPTH(IQ_DEPTH), .RESET_FILL(1'b0)) inst_queue (
        .clk(clk), .rst_n(rst_n), .flush(restore),
        .push(in_valid && in_ready), .push_data(in_req),
        .pop(iq_pop), .pop_data(iq_data), .empty(iq_empty), .full(iq_full)
    );

    // Free list never flushes, squashed registers come back through the ROB
    circular_fifo #(.T(rename_pkg::preg_t), .DEPTH(rename_pkg::FREE_REGS),
                    .RESET_FILL(1'b1)) free_list (
        .clk(clk), .rst_n(rst_n), .flush(1'b0),
        .push(release_valid), .push_data(release_preg),
        .pop(free_pop), .pop_data(free_head), .empty(), .full()
    );

    rename_table rat (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd),
        .rename_we(rename_we), .new_prd(new_prd),
        .retire_we(commit_valid), .retire_rd(commit.rd), .retire_prd(commit.prd),
        .restore(restore)
    );

    rename_stage stage (
        .clk(clk), .rst_n(rst_n), .flush(restore),
        .q_empty(iq_empty), .q_data(iq_data), .q_pop(iq_pop),
        .free_head(free_head), .free_pop(free_pop),
        .rob_full(rob_full), .rob_tail(rob_tail), .alloc(alloc), .alloc_entry(alloc_entry),
        .rs1(rs1), .rs2(rs2), .rd(rd), .prs1(prs1), .prs2(prs2), .old_prd(old_prd),
        .rename_we(rename_we), .new_prd(new_prd),
        .out_valid(out_valid), .out_ready(out_ready), .out_uop(out_uop)
    );

    reorder_buffer rob (
        .clk(clk), .rst_n(rst_n), .alloc(alloc), .alloc_entry(alloc_entry),
        .head(rob_head), .tail(rob_tail), .squash_step(squash_step),
        .cpl_valid(cpl_valid), .cpl(cpl),
        .commit_valid(commit_valid), .commit(commit),
        .release_valid(release_valid), .release_preg(release_preg)
    );

    rob_ptr_counter rob_ptrs (
        .clk(clk), .rst_n(rst_n), .alloc(alloc), .retire(commit_valid),
        .squash_step(squash_step), .head(rob_head), .tail(rob_tail),
        .full(rob_full), .empty(rob_empty)
    );

    recovery_fsm recovery (
        .clk(clk), .rst_n(rst_n), .commit_valid(commit_valid), .commit(commit),
        .rob_empty(rob_empty), .squash_step(squash_step), .restore(restore),
        .accepting(accepting)
    );

endmodule

/* source/rename_pkg.sv */
package rename_pkg;

    // Register file and ROB sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;
    localparam int ROB_DEPTH = 16;

    typedef logic [$clog2(ARCH_REGS)-1:0] areg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] preg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

    // Architectural instruction entering rename
    typedef struct packed {
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
    } rename_req_t;

    typedef struct packed {
        preg_t   prs1;
        preg_t   prs2;
        preg_t   prd;
        preg_t   old_prd;
        rob_id_t rob_id;
        logic    has_rd;
    } renamed_uop_t;

    // Completion report without a handshake
    typedef struct packed {
        rob_id_t rob_id;
        logic    mispredict;
    } completion_t;

    typedef struct packed {
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
        logic  has_rd;
        logic  mispredict;
    } commit_t;

    // Written into the ROB at rename
    typedef struct packed {
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
        logic  has_rd;
    } rob_alloc_t;

endpackage

/* source/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     q_empty,
    input  rename_pkg::rename_req_t  q_data,
    output logic                     q_pop,
    input  rename_pkg::preg_t        free_head,
    output logic                     free_pop,
    input  logic                     rob_full,
    input  rename_pkg::rob_id_t      rob_tail,
    output logic                     alloc,
    output rename_pkg::rob_alloc_t   alloc_entry,
    output rename_pkg::areg_t        rs1,
    output rename_pkg::areg_t        rs2,
    output rename_pkg::areg_t        rd,
    input  rename_pkg::preg_t        prs1,
    input  rename_pkg::preg_t        prs2,
    input  rename_pkg::preg_t        old_prd,
    output logic                     rename_we,
    output rename_pkg::preg_t        new_prd,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rename_pkg::renamed_uop_t out_uop
);

    logic                     has_rd;
    logic                     fire;
    rename_pkg::preg_t        prd;
    rename_pkg::preg_t        prev_prd;
    rename_pkg::renamed_uop_t uop_next;

    assign rs1 = q_data.rs1;
    assign rs2 = q_data.rs2;
    assign rd  = q_data.rd;

    // x0 destinations take no register
    assign has_rd   = (q_data.rd != '0);
    assign prd      = has_rd ? free_head : '0;
    assign prev_prd = has_rd ? old_prd : '0;

    // Advance when output slot is empty or being drained
    assign fire      = !flush && !q_empty && !rob_full && (!out_valid || out_ready);
    assign q_pop     = fire;
    assign alloc     = fire;
    assign free_pop  = fire && has_rd;
    assign rename_we = fire && has_rd;
    assign new_prd   = free_head;

    assign alloc_entry = '{rd: q_data.rd, prd: prd, old_prd: prev_prd, has_rd: has_rd};
    assign uop_next    = '{prs1: prs1, prs2: prs2, prd: prd, old_prd: prev_prd,
                           rob_id: rob_tail, has_rd: has_rd};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_uop <= uop_next;
        end
    end

endmodule

/* source/rename_table.sv */
`timescale 1ns/1ps

module rename_table (
    input  logic              clk,
    input  logic              rst_n,
    input  rename_pkg::areg_t rs1,
    input  rename_pkg::areg_t rs2,
    input  rename_pkg::areg_t rd,
    output rename_pkg::preg_t prs1,
    output rename_pkg::preg_t prs2,
    output rename_pkg::preg_t old_prd,
    input  logic              rename_we,
    input  rename_pkg::preg_t new_prd,
    input  logic              retire_we,
    input  rename_pkg::areg_t retire_rd,
    input  rename_pkg::preg_t retire_prd,
    input  logic              restore
);

    rename_pkg::preg_t spec_map    [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t retired_map [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t retired_next [rename_pkg::ARCH_REGS];

    // x0 is hardwired and never remapped
    assign prs1    = (rs1 == '0) ? '0 : spec_map[rs1];
    assign prs2    = (rs2 == '0) ? '0 : spec_map[rs2];
    assign old_prd = (rd == '0) ? '0 : spec_map[rd];

    // Retired view including this cycle's commit so that a restore sees it
    always_comb begin
        retired_next = retired_map;
        if (retire_we && retire_rd != '0) begin
            retired_next[retire_rd] = retire_prd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                retired_map[i] <= rename_pkg::preg_t'(i);
            end
        end else begin
            retired_map <= retired_next;
        end
    end

    // Speculative map reloads in one cycle on recovery
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= rename_pkg::preg_t'(i);
            end
        end else if (restore) begin
            spec_map <= retired_next;
        end else if (rename_we && rd != '0) begin
            spec_map[rd] <= new_prd;
        end
    end

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  rename_pkg::rob_alloc_t alloc_entry,
    input  rename_pkg::rob_id_t    head,
    input  rename_pkg::rob_id_t    tail,
    input  logic                   squash_step,
    input  logic                   cpl_valid,
    input  rename_pkg::completion_t cpl,
    output logic                   commit_valid,
    output rename_pkg::commit_t    commit,
    output logic                   release_valid,
    output rename_pkg::preg_t      release_preg
);

    // Per-entry status
    typedef struct packed {
        logic valid;
        logic done;
        logic mispredict;
    } rob_flags_t;

    rename_pkg::rob_alloc_t payload [rename_pkg::ROB_DEPTH];
    rob_flags_t             flags   [rename_pkg::ROB_DEPTH];
    rename_pkg::rob_id_t    squash_id;
    rename_pkg::rob_alloc_t head_entry;
    rename_pkg::rob_alloc_t squash_entry;

    assign squash_id    = tail - 1'b1;
    assign head_entry   = payload[head];
    assign squash_entry = payload[squash_id];

    // In-order commit from the head
    assign commit_valid       = flags[head].valid && flags[head].done && !squash_step;
    assign commit.rd          = head_entry.rd;
    assign commit.prd         = head_entry.prd;
    assign commit.old_prd     = head_entry.old_prd;
    assign commit.has_rd      = head_entry.has_rd;
    assign commit.mispredict  = flags[head].mispredict;

    // Commit frees the previous mapping, squash frees the new one
    assign release_valid = (commit_valid && head_entry.has_rd) ||
                           (squash_step && squash_entry.has_rd);
    assign release_preg  = squash_step ? squash_entry.prd : head_entry.old_prd;

    always_ff @(posedge clk) begin
        if (alloc) begin
            payload[tail] <= alloc_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
                flags[i] <= '0;
            end
        end else begin
            if (alloc) begin
                flags[tail] <= '{valid: 1'b1, done: 1'b0, mispredict: 1'b0};
            end
            // Late reports for entries no longer in flight are dropped
            if (cpl_valid && !squash_step && flags[cpl.rob_id].valid) begin
                flags[cpl.rob_id].done       <= 1'b1;
                flags[cpl.rob_id].mispredict <= cpl.mispredict;
            end
            if (commit_valid) begin
                flags[head].valid <= 1'b0;
            end
            if (squash_step) begin
                flags[squash_id].valid <= 1'b0;
            end
        end
    end

endmodule

/* source/rob_ptr_counter.sv */
`timescale 1ns/1ps

module rob_ptr_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc,
    input  logic                retire,
    input  logic                squash_step,
    output rename_pkg::rob_id_t head,
    output rename_pkg::rob_id_t tail,
    output logic                full,
    output logic                empty
);

    localparam int CW = $bits(rename_pkg::rob_id_t) + 1;

    logic [CW-1:0] count;

    assign full  = (count == CW'(rename_pkg::ROB_DEPTH));
    assign empty = (count == '0);

    // Indices wrap naturally since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;
            end
            if (squash_step) begin
                // Youngest entry goes first
                tail <= tail - 1'b1;
            end else if (alloc) begin
                tail <= tail + 1'b1;
            end
            count <= count + CW'(alloc) - CW'(retire) - CW'(squash_step);
        end
    end

endmodule

/* tests/rename_core_sva.sv */
`timescale 1ns/1ps

module rename_core_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     squash_step,
    input logic                     restore,
    input logic                     commit_valid,
    input logic                     out_valid,
    input logic                     out_ready,
    input rename_pkg::renamed_uop_t out_uop
);

    // Squashing keeps commit closed, also on the cycle the ROB drains
    no_commit_after_squash: assert property (@(posedge clk) disable iff (!rst_n)
        squash_step |=> !commit_valid)
        else $error("commit_valid high on the cycle after a ROB squash step");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !commit_valid)
        else $error("commit_valid high in the first cycle after reset");

    // A waiting uop holds until taken, unless recovery drops it
    uop_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !restore |=> out_valid && $stable(out_uop))
        else $error("out_uop changed or vanished while waiting for out_ready");

endmodule

bind rename_core rename_core_sva sva0 (
    .clk(clk),
    .rst_n(rst_n),
    .squash_step(squash_step),
    .restore(restore),
    .commit_valid(commit_valid),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_uop(out_uop)
);

/* tests/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb;

    localparam int IQ_DEPTH = 4;
    localparam int N_RANDOM = 60;
    localparam int N_STALL  = IQ_DEPTH + 2;
    localparam int N_BRANCH = 6;
    localparam int N_AFTER  = 12;
    localparam int N_TOTAL  = N_RANDOM + N_STALL + N_BRANCH + N_AFTER;
    localparam int MIS_POS  = 2;

    // One renamed instruction as the model tracks it
    typedef struct packed {
        rename_pkg::rob_id_t    rob_id;
        rename_pkg::rob_alloc_t alloc;
    } flight_t;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_ready;
    rename_pkg::rename_req_t  in_req;
    logic                     out_valid;
    logic                     out_ready;
    rename_pkg::renamed_uop_t out_uop;
    logic                     cpl_valid;
    rename_pkg::completion_t  cpl;
    logic                     commit_valid;
    rename_pkg::commit_t      commit;

    // Reference model state
    rename_pkg::preg_t       spec_rat    [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t       retired_rat [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t       free_q[$];
    flight_t                 in_flight[$];
    rename_pkg::rob_id_t     model_tail;
    bit                      mp_by_id [rename_pkg::ROB_DEPTH];

    // Traffic bookkeeping
    rename_pkg::rename_req_t accepted[$];
    rename_pkg::rob_id_t     to_complete[$];
    int                      accept_count;
    int                      out_count;
    bit                      accepted_last;
    bit                      mis_armed;
    rename_pkg::rob_id_t     mis_id;

    tb_clock #(.PERIOD(40)) clk_gen (.clk(clk));

    rename_core #(.IQ_DEPTH(IQ_DEPTH)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_req(in_req),
        .out_valid(out_valid), .out_ready(out_ready), .out_uop(out_uop),
        .cpl_valid(cpl_valid), .cpl(cpl),
        .commit_valid(commit_valid), .commit(commit)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else stop_with_failure($sformatf("mismatch at %0t %s got %b expected %b",
                                             $time, name, got, exp));
    endtask

    function automatic void reset_model();
        free_q.delete();
        in_flight.delete();
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            spec_rat[i]    = rename_pkg::preg_t'(i);
            retired_rat[i] = rename_pkg::preg_t'(i);
        end
        for (int i = 0; i < rename_pkg::FREE_REGS; i++) begin
            free_q.push_back(rename_pkg::preg_t'(rename_pkg::ARCH_REGS + i));
        end
        model_tail = '0;
    endfunction

    // Expected uop for the next request in program order
    function automatic rename_pkg::renamed_uop_t expect_uop(input rename_pkg::rename_req_t req);
        rename_pkg::renamed_uop_t u;
        flight_t                  f;
        u.prs1    = spec_rat[req.rs1];
        u.prs2    = spec_rat[req.rs2];
        u.has_rd  = (req.rd != '0);
        u.prd     = '0;
        u.old_prd = '0;
        if (u.has_rd) begin
            u.prd            = free_q.pop_front();
            u.old_prd        = spec_rat[req.rd];
            spec_rat[req.rd] = u.prd;
        end
        u.rob_id = model_tail;
        model_tail++;
        f.rob_id = u.rob_id;
        f.alloc  = '{rd: req.rd, prd: u.prd, old_prd: u.old_prd, has_rd: u.has_rd};
        in_flight.push_back(f);
        return u;
    endfunction

    // Oldest instruction retires; a mispredict throws away everything younger
    function automatic rename_pkg::commit_t expect_commit();
        flight_t             f;
        rename_pkg::commit_t c;
        f = in_flight.pop_front();
        c = '{rd: f.alloc.rd, prd: f.alloc.prd, old_prd: f.alloc.old_prd,
              has_rd: f.alloc.has_rd, mispredict: mp_by_id[f.rob_id]};
        if (f.alloc.has_rd) begin
            free_q.push_back(f.alloc.old_prd);
            retired_rat[f.alloc.rd] = f.alloc.prd;
        end
        if (c.mispredict) begin
            spec_rat = retired_rat;
            while (in_flight.size() > 0) begin
                f = in_flight.pop_back();
                if (f.alloc.has_rd) begin
                    free_q.push_back(f.alloc.prd);
                end
                model_tail--;
            end
        end
        return c;
    endfunction

    function automatic rename_pkg::rename_req_t random_req();
        rename_pkg::rename_req_t r;
        r.rd  = ($urandom_range(5) == 0) ? '0 : rename_pkg::areg_t'($urandom_range(31));
        r.rs1 = rename_pkg::areg_t'($urandom_range(31));
        r.rs2 = rename_pkg::areg_t'($urandom_range(31));
        return r;
    endfunction

    // One falling-edge step of input traffic
    task automatic drive_cycle(input int target, input int ready_pct, input bit complete);
        bit send;
        int idx;
        @(negedge clk);
        send = (accept_count < target);
        if (!in_valid || accepted_last) begin
            in_valid = send && ($urandom_range(3) != 0);
            in_req   = random_req();
        end
        out_ready = ($urandom_range(99) < ready_pct);
        cpl_valid = 1'b0;
        if (complete && to_complete.size() > 0 && $urandom_range(1) == 1) begin
            idx            = $urandom_range(to_complete.size() - 1);
            cpl.rob_id     = to_complete[idx];
            cpl.mispredict = mis_armed && (to_complete[idx] == mis_id);
            mp_by_id[cpl.rob_id] = cpl.mispredict;
            to_complete.delete(idx);
            cpl_valid = 1'b1;
        end
    endtask

    task automatic drain();
        while (in_valid || out_count != accept_count || in_flight.size() != 0 ||
               to_complete.size() != 0) begin
            drive_cycle(accept_count, 100, 1'b1);
        end
    endtask

    // Compare process samples pre-edge values at each rising edge
    always @(posedge clk) begin : compare
        rename_pkg::commit_t      exp_commit;
        rename_pkg::renamed_uop_t exp_uop;
        if (rst_n) begin
            if (commit_valid) begin
                assert (in_flight.size() > 0)
                    else stop_with_failure($sformatf("commit at %0t with nothing in flight",
                                                     $time));
                exp_commit = expect_commit();
                assert (commit == exp_commit)
                    else stop_with_failure($sformatf("mismatch at %0t commit got %h expected %h",
                                                     $time, commit, exp_commit));
            end
            if (out_valid && out_ready) begin
                assert (accepted.size() > 0)
                    else stop_with_failure($sformatf("uop at %0t without an accepted request",
                                                     $time));
                exp_uop = expect_uop(accepted.pop_front());
                assert (out_uop == exp_uop)
                    else stop_with_failure($sformatf("mismatch at %0t out_uop got %h expected %h",
                                                     $time, out_uop, exp_uop));
                to_complete.push_back(out_uop.rob_id);
                out_count++;
            end
            accepted_last = in_valid && in_ready;
            if (accepted_last) begin
                accepted.push_back(in_req);
                accept_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (400 * N_TOTAL) @(posedge clk);
        stop_with_failure("timeout, the DUT did not finish the test sequence in time");
    end

    initial begin
        int base;
        void'($urandom(32'hbe57));
        reset_model();
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b0;
        cpl_valid     = 1'b0;
        cpl           = '0;
        accept_count  = 0;
        out_count     = 0;
        accepted_last = 1'b0;
        mis_armed     = 1'b0;
        mis_id        = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("commit_valid", commit_valid, 1'b0);

        // Random traffic with back-pressure and out-of-order completion
        base = accept_count;
        while (accept_count < base + N_RANDOM) begin
            drive_cycle(base + N_RANDOM, 70, 1'b1);
        end
        drain();

        // Output held back until the queue fills
        base = accept_count;
        while (accept_count < base + IQ_DEPTH + 1) begin
            drive_cycle(base + N_STALL, 0, 1'b0);
        end
        repeat (2 * IQ_DEPTH) drive_cycle(base + N_STALL, 0, 1'b0);
        assert (accept_count == base + IQ_DEPTH + 1)
            else stop_with_failure($sformatf("mismatch at %0t accept_count got %0d expected %0d",
                                             $time, accept_count, base + IQ_DEPTH + 1));
        check_bit("in_ready", in_ready, 1'b0);
        drain();

        // Mispredicted branch in the middle of a batch
        base = accept_count;
        while (out_count < base + N_BRANCH) begin
            drive_cycle(base + N_BRANCH, 100, 1'b0);
        end
        mis_id    = to_complete[MIS_POS];
        mis_armed = 1'b1;
        while (to_complete.size() > 0 || in_flight.size() > 0) begin
            drive_cycle(accept_count, 100, 1'b1);
        end
        while (!in_ready) begin
            drive_cycle(accept_count, 100, 1'b1);
        end
        mis_armed = 1'b0;

        // Renaming resumes from the retired state
        base = accept_count;
        while (accept_count < base + N_AFTER) begin
            drive_cycle(base + N_AFTER, 80, 1'b1);
        end
        drain();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* vlog.f */
source/rename_pkg.sv
source/circular_fifo.sv
source/rename_table.sv
source/rob_ptr_counter.sv
source/reorder_buffer.sv
source/recovery_fsm.sv
source/rename_stage.sv
source/rename_core.sv
tests/tb_clock.sv
tests/rename_core_sva.sv
tests/rename_core_tb.sv
